//--- source/audio_level_params.svh
`ifndef AUDIO_LEVEL_PARAMS_SVH
`define AUDIO_LEVEL_PARAMS_SVH

// clk cycles per half period of the I2S bit clock
`define I2S_CLK_DIV 4

// serial bits per frame, the signed sample sits in the first nine
`define I2S_FRAME_BITS 32

// number of magnitudes the sample FIFO can hold
`define SAMPLE_FIFO_DEPTH 8

// consumed samples per peak report
`define METER_WINDOW 4

`endif

//--- source/audio_level_pkg.sv
`default_nettype none

`include "audio_level_params.svh"

package audio_level_pkg;

    typedef logic [7:0] sample_mag_t;                               // saturated unsigned magnitude

    typedef logic [$clog2(`I2S_FRAME_BITS)-1:0] frame_bit_t;        // bit position inside a frame

    typedef logic signed [8:0] raw_sample_t;                        // two's complement head of a frame

    typedef logic [3:0] window_count_t;                             // samples seen in a meter window

endpackage

`default_nettype wire

//--- source/i2s_clock_gen.sv
`default_nettype none

`include "audio_level_params.svh"

module i2s_clock_gen (
    input  wire  clk,
    input  wire  rst,
    output logic sclk,
    output logic sclk_rise,
    output logic sclk_fall
);

    localparam int div_w = $clog2(`I2S_CLK_DIV);
    localparam logic [div_w-1:0] div_last = div_w'(`I2S_CLK_DIV - 1);

    logic [div_w-1:0] div_cnt;
    logic [div_w-1:0] div_cnt_n;
    logic             sclk_n;
    logic             sclk_q;                                       // sclk delayed by one clk

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            sclk    <= 1'b0;
            sclk_q  <= 1'b0;
        end else begin
            div_cnt <= div_cnt_n;
            sclk    <= sclk_n;
            sclk_q  <= sclk;
        end
    end

    always_comb begin
        div_cnt_n = div_cnt + 1'b1;
        sclk_n    = sclk;
        if (div_cnt == div_last) begin                              // half period done, flip the bit clock
            div_cnt_n = '0;
            sclk_n    = ~sclk;
        end
    end

    // sclk changed at the last clk edge but the delayed copy has not caught up yet
    assign sclk_rise = sclk & ~sclk_q;
    assign sclk_fall = ~sclk & sclk_q;

endmodule

`default_nettype wire

//--- source/i2s_sample_receiver.sv
`default_nettype none

`include "audio_level_params.svh"

module i2s_sample_receiver (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         sclk_rise,
    input  wire                         sclk_fall,
    input  wire                         adc_sdata,
    output logic                        ws,
    output audio_level_pkg::sample_mag_t sample_mag,
    output logic                        sample_valid
);

    import audio_level_pkg::*;

    localparam frame_bit_t last_bit = frame_bit_t'(`I2S_FRAME_BITS - 1);

    frame_bit_t                 bit_cnt;
    frame_bit_t                 bit_cnt_n;
    logic [`I2S_FRAME_BITS-1:0] shift_q;                            // msb first, oldest bit on the left
    logic [`I2S_FRAME_BITS-1:0] shift_n;
    logic                       ws_n;
    logic                       sample_valid_n;
    sample_mag_t                sample_mag_n;
    raw_sample_t                raw_sample;
    logic [8:0]                 raw_abs;
    sample_mag_t                mag_sat;

    // on the strobe of the last bit, frame bits 0..8 sit just below the top of the register
    assign raw_sample = shift_q[`I2S_FRAME_BITS-2 -: $bits(raw_sample_t)];

    // absolute value in nine bits, only -256 needs the ninth bit
    assign raw_abs = raw_sample[8] ? (~raw_sample) + 1'b1 : raw_sample;
    assign mag_sat = raw_abs[8] ? 8'hff : raw_abs[7:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bit_cnt      <= '0;
            ws           <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            bit_cnt      <= bit_cnt_n;
            ws           <= ws_n;
            sample_valid <= sample_valid_n;
        end
    end

    always_ff @(posedge clk) begin
        shift_q    <= shift_n;
        sample_mag <= sample_mag_n;
    end

    always_comb begin
        bit_cnt_n      = bit_cnt;
        shift_n        = shift_q;
        ws_n           = ws;
        sample_mag_n   = sample_mag;
        sample_valid_n = 1'b0;
        if (sclk_rise) begin
            shift_n   = {shift_q[`I2S_FRAME_BITS-2:0], adc_sdata};
            bit_cnt_n = (bit_cnt == last_bit) ? '0 : bit_cnt + 1'b1;
            if (bit_cnt == last_bit) begin                          // last bit of the frame, publish the head sample
                sample_mag_n   = mag_sat;
                sample_valid_n = 1'b1;
            end
        end else if (sclk_fall && bit_cnt == '0) begin
            // a zero count at a falling edge only happens right after the last bit
            ws_n = ~ws;
        end
    end

    // a sample leaves only in the cycle after the counter wrapped on a rising strobe
    assert property (@(posedge clk) disable iff (rst)
        sample_valid |-> (bit_cnt == '0) && $past(sclk_rise))
        else $error("sample_valid raised without a frame wrap");

endmodule

`default_nettype wire

//--- source/sample_fifo.sv
`default_nettype none

`include "audio_level_params.svh"

module sample_fifo (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          wr,
    input  wire audio_level_pkg::sample_mag_t wr_data,
    input  wire                          pop,
    output audio_level_pkg::sample_mag_t head_mag,
    output logic                         fifo_empty,
    output logic                         overflow
);

    import audio_level_pkg::*;

    localparam int ptr_w   = $clog2(`SAMPLE_FIFO_DEPTH);
    localparam int count_w = $clog2(`SAMPLE_FIFO_DEPTH + 1);
    localparam logic [ptr_w-1:0]   ptr_last = ptr_w'(`SAMPLE_FIFO_DEPTH - 1);
    localparam logic [count_w-1:0] depth    = count_w'(`SAMPLE_FIFO_DEPTH);

    sample_mag_t        mem [`SAMPLE_FIFO_DEPTH];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [count_w-1:0] count;                                      // entries currently stored
    logic               full;
    logic               wr_accept;

    assign full       = (count == depth);
    assign fifo_empty = (count == '0);
    assign wr_accept  = wr & ~full;                                 // a write into a full buffer is lost
    assign head_mag   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_accept) begin
                wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_accept, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                            // both or neither leave the level alone
            endcase
            if (wr && full) begin
                overflow <= 1'b1;                                   // stays set until reset
            end
        end
    end

    // the meter has to look at fifo_empty before it pops
    assert property (@(posedge clk) disable iff (rst) pop |-> !fifo_empty)
        else $error("pop while the FIFO is empty");

    assert property (@(posedge clk) disable iff (rst) count <= depth)
        else $error("FIFO occupancy above its depth");

endmodule

`default_nettype wire

//--- source/peak_level_meter.sv
`default_nettype none

`include "audio_level_params.svh"

module peak_level_meter (
    input  wire                               clk,
    input  wire                               rst,
    input  wire                               fifo_empty,
    input  wire audio_level_pkg::sample_mag_t head_mag,
    input  wire                               meter_hold,
    output logic                              pop,
    output audio_level_pkg::sample_mag_t      peak_level,
    output logic                              peak_valid
);

    import audio_level_pkg::*;

    localparam window_count_t window_last = window_count_t'(`METER_WINDOW - 1);

    sample_mag_t   run_max;                                         // largest magnitude so far in this window
    sample_mag_t   run_max_n;
    sample_mag_t   new_max;
    sample_mag_t   peak_level_n;
    window_count_t win_cnt;
    window_count_t win_cnt_n;
    logic          pop_n;
    logic          peak_valid_n;

    assign new_max = (head_mag > run_max) ? head_mag : run_max;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pop        <= 1'b0;
            run_max    <= '0;
            win_cnt    <= '0;
            peak_level <= '0;
            peak_valid <= 1'b0;
        end else begin
            pop        <= pop_n;
            run_max    <= run_max_n;
            win_cnt    <= win_cnt_n;
            peak_level <= peak_level_n;
            peak_valid <= peak_valid_n;
        end
    end

    always_comb begin
        // skip the cycle after a pop so fifo_empty has settled
        pop_n        = ~fifo_empty & ~meter_hold & ~pop;
        run_max_n    = run_max;
        win_cnt_n    = win_cnt;
        peak_level_n = peak_level;
        peak_valid_n = 1'b0;
        if (pop) begin                                              // head_mag is the entry being removed
            if (win_cnt == window_last) begin
                peak_level_n = new_max;
                peak_valid_n = 1'b1;
                run_max_n    = '0;
                win_cnt_n    = '0;
            end else begin
                run_max_n = new_max;
                win_cnt_n = win_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/audio_level_top.sv
`default_nettype none

module audio_level_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          adc_sdata,
    input  wire                          meter_hold,
    output logic                         sclk,
    output logic                         ws,
    output audio_level_pkg::sample_mag_t peak_level,
    output logic                         peak_valid,
    output logic                         overflow
);

    import audio_level_pkg::*;

    logic        sclk_rise;
    logic        sclk_fall;
    logic        sample_valid;
    sample_mag_t sample_mag;
    logic        fifo_empty;
    logic        pop;
    sample_mag_t head_mag;

    i2s_clock_gen clock_gen_i (
        .clk       (clk),
        .rst       (rst),
        .sclk      (sclk),
        .sclk_rise (sclk_rise),
        .sclk_fall (sclk_fall)
    );

    i2s_sample_receiver receiver_i (
        .clk          (clk),
        .rst          (rst),
        .sclk_rise    (sclk_rise),
        .sclk_fall    (sclk_fall),
        .adc_sdata    (adc_sdata),
        .ws           (ws),
        .sample_mag   (sample_mag),
        .sample_valid (sample_valid)
    );

    sample_fifo fifo_i (
        .clk        (clk),
        .rst        (rst),
        .wr         (sample_valid),
        .wr_data    (sample_mag),
        .pop        (pop),
        .head_mag   (head_mag),
        .fifo_empty (fifo_empty),
        .overflow   (overflow)
    );

    peak_level_meter meter_i (
        .clk        (clk),
        .rst        (rst),
        .fifo_empty (fifo_empty),
        .head_mag   (head_mag),
        .meter_hold (meter_hold),
        .pop        (pop),
        .peak_level (peak_level),
        .peak_valid (peak_valid)
    );

endmodule

`default_nettype wire

//--- verification/adc_serial_model.sv
`default_nettype none

`include "audio_level_params.svh"

module adc_serial_model (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          sclk,
    output logic                         adc_sdata,
    output audio_level_pkg::frame_bit_t  bit_pos,
    output logic [4:0]                   frame_cnt,
    output audio_level_pkg::sample_mag_t frame_mag
);

    import audio_level_pkg::*;

    localparam frame_bit_t last_bit = frame_bit_t'(`I2S_FRAME_BITS - 1);

    logic [`I2S_FRAME_BITS-1:0] frame = '0;                         // bit 0 of the frame sits at the top
    frame_bit_t                 pos = '0;
    logic                       sclk_prev = 1'b0;
    logic                       loaded = 1'b0;
    int unsigned                made = 0;
    logic                       sdata_q = 1'b0;
    frame_bit_t                 pos_q = '0;
    logic [4:0]                 cnt_q = '0;
    sample_mag_t                mag_q = '0;

    assign adc_sdata = sdata_q;
    assign bit_pos   = pos_q;
    assign frame_cnt = cnt_q;
    assign frame_mag = mag_q;

    // magnitude of the nine head bits, taken as two's complement with bit 0 as the sign
    function automatic sample_mag_t expected_mag(input logic [8:0] head);
        int value;
        value = int'(head);
        if (head[8]) value = value - 512;
        if (value < 0) value = -value;
        if (value > 255) value = 255;                               // only -256 lands here
        return sample_mag_t'(value);
    endfunction

    function automatic logic [`I2S_FRAME_BITS-1:0] next_frame();
        logic [`I2S_FRAME_BITS-1:0] f;
        f = $urandom;
        if (made % 8 == 7) f[`I2S_FRAME_BITS-1 -: 9] = 9'h100;      // every eighth frame opens with -256
        made = made + 1;
        return f;
    endfunction

    always @(negedge clk) begin
        if (rst) begin
            if (!loaded) begin
                frame  = next_frame();
                loaded = 1'b1;
            end
            pos       = '0;
            sclk_prev = 1'b0;
            cnt_q    <= '0;
        end else begin
            if (sclk_prev && !sclk) begin                           // bit clock fell, the next bit goes out
                if (pos == last_bit) begin
                    frame = next_frame();
                    pos   = '0;
                end else begin
                    pos = pos + 1'b1;
                end
                if (pos == last_bit) begin                          // announce the frame with its last bit
                    mag_q <= expected_mag(frame[last_bit -: 9]);
                    cnt_q <= cnt_q + 1'b1;
                end
            end
            sclk_prev = sclk;
        end
        sdata_q <= frame[last_bit - pos];
        pos_q   <= pos;
    end

endmodule

`default_nettype wire

//--- verification/tb_audio_level.sv
`default_nettype none

`include "audio_level_params.svh"

module tb_audio_level;

    import audio_level_pkg::*;

    localparam int frame_clks   = 2 * `I2S_CLK_DIV * `I2S_FRAME_BITS;
    localparam int short_frames = 40;                               // frames with short random holds
    localparam int peak_limit   = 2 * `METER_WINDOW * frame_clks;

    logic        clk = 1'b0;
    logic        rst;
    logic        meter_hold = 1'b0;
    logic        adc_sdata;
    logic        sclk;
    logic        ws;
    sample_mag_t peak_level;
    logic        peak_valid;
    logic        overflow;
    frame_bit_t  bit_pos;
    logic [4:0]  frame_cnt;
    sample_mag_t frame_mag;

    sample_mag_t held_q[$];                                         // samples parked in the FIFO by a hold
    sample_mag_t peak_q[$];                                         // peaks the DUT still has to report
    sample_mag_t win_max = '0;
    int          win_n = 0;
    logic        overflow_exp = 1'b0;
    int          phase = 1;
    int          hold_left = 0;
    int          end_frame = 0;
    int          frames = 0;
    logic [4:0]  last_frame_cnt = '0;
    frame_bit_t  last_bit_pos = '0;
    int          cyc = 0;
    int          sclk_at = -1;
    int          ws_at = -1;
    int          ws_toggles = 0;
    logic        sclk_last = 1'b0;
    logic        ws_last = 1'b0;
    int          since_peak = 0;
    int          hold_cyc = 0;

    always #10 clk = ~clk;

    audio_level_top audio_level_top_i (
        .clk        (clk),
        .rst        (rst),
        .adc_sdata  (adc_sdata),
        .meter_hold (meter_hold),
        .sclk       (sclk),
        .ws         (ws),
        .peak_level (peak_level),
        .peak_valid (peak_valid),
        .overflow   (overflow)
    );

    adc_serial_model adc_model_i (
        .clk       (clk),
        .rst       (rst),
        .sclk      (sclk),
        .adc_sdata (adc_sdata),
        .bit_pos   (bit_pos),
        .frame_cnt (frame_cnt),
        .frame_mag (frame_mag)
    );

    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "first error ends the run");
    endtask

    task automatic report_mismatch(input string what);
        $display("mismatch at %0t: %s", $time, what);
        stop_run();
    endtask

    task automatic report_failure(input string what);
        $display("%s at time %0t", what, $time);
        stop_run();
    endtask

    task automatic feed_meter_model(input sample_mag_t m);
        if (m > win_max) win_max = m;
        win_n++;
        if (win_n == `METER_WINDOW) begin                           // window closed, the DUT owes a peak
            peak_q.push_back(win_max);
            win_max = '0;
            win_n   = 0;
        end
    endtask

    task automatic take_sample(input sample_mag_t m);
        if (!meter_hold) begin
            feed_meter_model(m);
        end else if (held_q.size() < `SAMPLE_FIFO_DEPTH) begin
            held_q.push_back(m);
        end else begin
            overflow_exp = 1'b1;                                    // a full FIFO drops this one
        end
    endtask

    task automatic release_hold();
        meter_hold = 1'b0;
        while (held_q.size() > 0) feed_meter_model(held_q.pop_front());
    endtask

    // runs at bit 16 of each frame, far away from frame ends and FIFO drains
    task automatic update_hold();
        assert (overflow == overflow_exp)
            else report_mismatch($sformatf("overflow %0b, expected %0b", overflow, overflow_exp));
        case (phase)
            1: begin
                if (meter_hold) begin
                    hold_left--;
                    if (hold_left == 0) release_hold();
                end else if (frames >= short_frames) begin
                    phase      = 2;
                    meter_hold = 1'b1;
                    hold_left  = `SAMPLE_FIFO_DEPTH + 1 + int'($urandom % 3);
                end else if ($urandom % 4 == 0) begin
                    meter_hold = 1'b1;
                    hold_left  = 1 + int'($urandom % 6);            // never more frames than FIFO entries
                end
            end
            2: begin
                hold_left--;
                if (hold_left == 0) begin
                    release_hold();
                    phase     = 3;
                    end_frame = frames + 12;
                end
            end
            3: if (frames >= end_frame) phase = 4;
            default: ;
        endcase
    endtask

    task automatic check_peak();
        sample_mag_t expected;
        since_peak++;
        if (meter_hold) hold_cyc++;
        if (peak_valid) begin
            assert (peak_q.size() > 0) else report_mismatch("peak_valid without a finished window");
            expected = peak_q.pop_front();
            assert (peak_level == expected)
                else report_mismatch($sformatf("peak_level %0d, expected %0d", peak_level, expected));
            since_peak = 0;
            hold_cyc   = 0;
        end
        assert (since_peak <= peak_limit + hold_cyc) else report_failure("timeout waiting for peak_valid");
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            cyc++;
            if (sclk != sclk_last) begin
                if (sclk_at >= 0) begin
                    assert (cyc - sclk_at == `I2S_CLK_DIV)
                        else report_mismatch($sformatf("sclk half period %0d", cyc - sclk_at));
                end
                sclk_at   = cyc;
                sclk_last = sclk;
            end
            if (ws != ws_last) begin                                // ws flips once per frame
                if (ws_at >= 0) begin
                    assert (cyc - ws_at == frame_clks)
                        else report_mismatch($sformatf("ws period %0d clk cycles", cyc - ws_at));
                end
                ws_at   = cyc;
                ws_last = ws;
                ws_toggles++;
            end
            if (frame_cnt != last_frame_cnt) begin
                last_frame_cnt = frame_cnt;
                frames++;
                take_sample(frame_mag);
            end
            if (bit_pos == 5'd16 && last_bit_pos != 5'd16) update_hold();
            last_bit_pos = bit_pos;
            check_peak();
        end
    end

    initial begin
        int waited;
        void'($urandom(32'h1e16_9787));
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (!sclk && !ws && !peak_valid && !overflow && peak_level == '0)
            else report_mismatch("outputs not idle after reset");
        waited = 0;
        while (phase != 4 && waited < 100 * frame_clks) begin
            @(posedge clk);
            waited++;
        end
        assert (phase == 4) else report_failure("timeout before the hold phases finished");
        waited = 0;
        while (peak_q.size() != 0 && waited < peak_limit) begin
            @(posedge clk);
            waited++;
        end
        assert (peak_q.size() == 0) else report_failure("timeout waiting for the last peak reports");
        @(negedge clk);
        assert (overflow && overflow_exp) else report_mismatch("overflow low after the long hold");
        assert (ws_toggles > 0) else report_failure("ws never toggled");
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+source
source/audio_level_pkg.sv
source/i2s_clock_gen.sv
source/i2s_sample_receiver.sv
source/sample_fifo.sv
source/peak_level_meter.sv
source/audio_level_top.sv
verification/adc_serial_model.sv
verification/tb_audio_level.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and reads the verdict from the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
if ! verilator --binary --timing --assert --top-module tb_audio_level \
        -f sim.f --Mdir obj_dir -o tb_audio_level; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_audio_level > sim.log 2>&1
run_status=$?
cat sim.log
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
fi

if grep -qx "sim passed" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
